/* logic/rename_pkg.sv */
package rename_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int DISP_SIZE  = 2;    // lanes renamed per group
  localparam int ARCH_REGS  = 32;
  localparam int AREG_W     = $clog2(ARCH_REGS);
  localparam int FLIST_SIZE = 16;   // ids held by one lane free list
  localparam int RNID_SIZE  = ARCH_REGS + DISP_SIZE * FLIST_SIZE;
  localparam int RNID_W     = $clog2(RNID_SIZE);
  localparam int NUM_SRC    = 2;
  localparam int WB_PORTS   = 2;

  typedef logic [RNID_W-1:0] rnid_t;

  // --------------------------------------------------
  // front side, group coming in
  // --------------------------------------------------
  typedef struct packed {
    logic              valid;
    logic [AREG_W-1:0] regidx;
  } rn_src_t;

  typedef struct packed {
    logic                     valid;
    logic                     rd_valid;
    logic [AREG_W-1:0]        rd_regidx;
    rn_src_t [NUM_SRC-1:0]    src;
  } rn_inst_t;

  typedef struct packed {
    rn_inst_t [DISP_SIZE-1:0] inst;
  } rn_group_t;

  // renamed group going out
  typedef struct packed {
    logic                     valid;
    logic                     rd_valid;
    logic [AREG_W-1:0]        rd_regidx;
    rnid_t                    rd_rnid;
    rnid_t                    rd_old_rnid;
    rnid_t [NUM_SRC-1:0]      src_rnid;
    logic [NUM_SRC-1:0]       src_ready;
  } rn_out_inst_t;

  typedef struct packed {
    rn_out_inst_t [DISP_SIZE-1:0] inst;
  } rn_result_t;

  // --------------------------------------------------
  // back side, writeback and commit
  // --------------------------------------------------
  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } rn_wb_t;

  typedef struct packed {
    logic              rd_valid;
    logic              dead;       // flushed instruction, give back new id
    logic [AREG_W-1:0] rd_regidx;
    rnid_t             rnid;
    rnid_t             old_rnid;
  } rn_cmt_lane_t;

  typedef struct packed {
    logic                         commit;
    rn_cmt_lane_t [DISP_SIZE-1:0] lane;
  } rn_commit_t;

endpackage

/* logic/rn_freelist.sv */
`timescale 1ns/1ns

module rn_freelist #(
  parameter int INIT_BASE = 32
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_push,
  input  rename_pkg::rnid_t i_push_id,
  input  logic              i_pop,
  output rename_pkg::rnid_t o_pop_id,
  output logic              o_empty
);

  logic [$clog2(rename_pkg::FLIST_SIZE)-1:0] r_head;
  logic [$clog2(rename_pkg::FLIST_SIZE)-1:0] r_tail;
  logic [$clog2(rename_pkg::FLIST_SIZE):0]   r_count;
  rename_pkg::rnid_t                         r_ids [rename_pkg::FLIST_SIZE];

  assign o_pop_id = r_ids[r_head];    // oldest free id
  assign o_empty  = (r_count == '0);

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;                  // list starts full, tail sits on head
      r_count <= $bits(r_count)'(rename_pkg::FLIST_SIZE);
    end else begin
      if (i_pop) begin
        r_head <= r_head + 1'b1;      // size is a power of two, wraps freely
      end
      if (i_push) begin
        r_tail <= r_tail + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // storage, loaded with the lane's own id range at reset
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < rename_pkg::FLIST_SIZE; i++) begin
        r_ids[i] <= rename_pkg::rnid_t'(INIT_BASE + i);
      end
    end else if (i_push) begin
      r_ids[r_tail] <= i_push_id;
    end
  end

endmodule

/* logic/rn_map_table.sv */
`timescale 1ns/1ns

module rn_map_table (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  rename_pkg::rn_group_t i_group,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] o_src_rnid,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] o_rd_old_rnid,
  input  logic [rename_pkg::DISP_SIZE-1:0]              i_update,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] i_update_rnid,
  input  logic                                          i_restore,
  input  rename_pkg::rnid_t i_restore_map [rename_pkg::ARCH_REGS]
);

  rename_pkg::rnid_t r_map [rename_pkg::ARCH_REGS];   // speculative arch -> phys

  // --------------------------------------------------
  // lookups for the whole group
  // --------------------------------------------------
  generate
    for (genvar d = 0; d < rename_pkg::DISP_SIZE; d++) begin : g_lane
      for (genvar s = 0; s < rename_pkg::NUM_SRC; s++) begin : g_src
        assign o_src_rnid[d][s] = r_map[i_group.inst[d].src[s].regidx];
      end
      // old mapping of rd, returned at commit
      assign o_rd_old_rnid[d] = r_map[i_group.inst[d].rd_regidx];
    end
  endgenerate

  // --------------------------------------------------
  // update and restore
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
        r_map[r] <= rename_pkg::rnid_t'(r);   // identity mapping
      end
    end else if (i_restore) begin
      r_map <= i_restore_map;                 // flush wins over renames
    end else begin
      // lane order, so a later lane to the same rd lands last
      for (int d = 0; d < rename_pkg::DISP_SIZE; d++) begin
        if (i_update[d]) begin
          r_map[i_group.inst[d].rd_regidx] <= i_update_rnid[d];
        end
      end
    end
  end

endmodule

/* logic/rn_commit_map.sv */
`timescale 1ns/1ns

module rn_commit_map (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  rename_pkg::rn_commit_t i_commit,
  output rename_pkg::rnid_t      o_map [rename_pkg::ARCH_REGS]
);

  rename_pkg::rnid_t r_map [rename_pkg::ARCH_REGS];

  // committed map with this cycle's commit already folded in,
  // so a flush in the same cycle as the last commit restores it
  always_comb begin
    o_map = r_map;
    if (i_commit.commit) begin
      for (int d = 0; d < rename_pkg::DISP_SIZE; d++) begin
        if (i_commit.lane[d].rd_valid & ~i_commit.lane[d].dead &
            (i_commit.lane[d].rd_regidx != '0)) begin
          o_map[i_commit.lane[d].rd_regidx] = i_commit.lane[d].rnid;
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
        r_map[r] <= rename_pkg::rnid_t'(r);
      end
    end else begin
      r_map <= o_map;
    end
  end

endmodule

/* logic/rn_busy_table.sv */
`timescale 1ns/1ns

module rn_busy_table (
  input  logic i_clk,
  input  logic i_reset_n,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] i_rnid,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0]              o_ready,
  input  logic [rename_pkg::DISP_SIZE-1:0]              i_alloc,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] i_alloc_rnid,
  input  rename_pkg::rn_wb_t                            i_wb [rename_pkg::WB_PORTS]
);

  logic [rename_pkg::RNID_SIZE-1:0] r_busy;     // result still in flight
  logic [rename_pkg::RNID_SIZE-1:0] w_wb_hit;
  logic [rename_pkg::RNID_SIZE-1:0] w_alloc_set;

  // decode writeback and allocation ids into bit masks
  always_comb begin
    w_wb_hit    = '0;
    w_alloc_set = '0;
    for (int p = 0; p < rename_pkg::WB_PORTS; p++) begin
      if (i_wb[p].valid) begin
        w_wb_hit[i_wb[p].rnid] = 1'b1;
      end
    end
    for (int d = 0; d < rename_pkg::DISP_SIZE; d++) begin
      if (i_alloc[d]) begin
        w_alloc_set[i_alloc_rnid[d]] = 1'b1;
      end
    end
  end

  generate
    for (genvar d = 0; d < rename_pkg::DISP_SIZE; d++) begin : g_lane
      for (genvar s = 0; s < rename_pkg::NUM_SRC; s++) begin : g_src
        // id 0 is x0, a writeback this cycle counts as done
        assign o_ready[d][s] = (i_rnid[d][s] == '0) | ~r_busy[i_rnid[d][s]] |
                               w_wb_hit[i_rnid[d][s]];
      end
    end
  endgenerate

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy <= '0;
    end else begin
      r_busy <= (r_busy & ~w_wb_hit) | w_alloc_set;
    end
  end

endmodule

/* logic/rn_group_bypass.sv */
`timescale 1ns/1ns

module rn_group_bypass (
  input  rename_pkg::rn_group_t                         i_group,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] i_new_rnid,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] i_map_src_rnid,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] i_map_old_rnid,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] o_src_rnid,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0]              o_src_fwd,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] o_rd_old_rnid
);

  logic [rename_pkg::DISP_SIZE-1:0] w_writes;   // lane allocates a new id

  generate
    for (genvar d = 0; d < rename_pkg::DISP_SIZE; d++) begin : g_wr
      assign w_writes[d] = i_group.inst[d].valid & i_group.inst[d].rd_valid &
                           (i_group.inst[d].rd_regidx != '0);
    end
  endgenerate

  // --------------------------------------------------
  // intra-group dependency scan
  // --------------------------------------------------
  always_comb begin
    o_src_rnid    = i_map_src_rnid;
    o_src_fwd     = '0;
    o_rd_old_rnid = i_map_old_rnid;
    for (int d = 1; d < rename_pkg::DISP_SIZE; d++) begin
      // walk older lanes upward, nearest older writer ends up on top
      for (int p = 0; p < d; p++) begin
        if (w_writes[p]) begin
          for (int s = 0; s < rename_pkg::NUM_SRC; s++) begin
            if (i_group.inst[p].rd_regidx == i_group.inst[d].src[s].regidx) begin
              o_src_rnid[d][s] = i_new_rnid[p];
              o_src_fwd[d][s]  = 1'b1;
            end
          end
          if (i_group.inst[p].rd_regidx == i_group.inst[d].rd_regidx) begin
            o_rd_old_rnid[d] = i_new_rnid[p];   // WAW inside the group
          end
        end
      end
    end
  end

endmodule

/* logic/rn_rename_top.sv */
`timescale 1ns/1ns

module rn_rename_top (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_valid,
  input  rename_pkg::rn_group_t  i_group,
  output logic                   o_ready,
  output logic                   o_valid,
  output rename_pkg::rn_result_t o_group,
  input  rename_pkg::rn_wb_t     i_wb [rename_pkg::WB_PORTS],
  input  rename_pkg::rn_commit_t i_commit,
  input  logic                   i_flush
);

  logic                                          w_fire;
  logic [rename_pkg::DISP_SIZE-1:0]              w_empty;
  logic [rename_pkg::DISP_SIZE-1:0]              w_alloc;       // lane wants an id
  logic [rename_pkg::DISP_SIZE-1:0]              w_alloc_fire;
  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] w_pop_id;
  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] w_new_rnid;
  logic [rename_pkg::DISP_SIZE-1:0]              w_push;
  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] w_push_id;
  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] w_map_src_rnid;
  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] w_src_rnid;
  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0]              w_src_fwd;
  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0]              w_busy_ready;
  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] w_map_old_rnid;
  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0] w_rd_old_rnid;
  rename_pkg::rnid_t                             w_cmt_map [rename_pkg::ARCH_REGS];
  rename_pkg::rn_commit_t                        r_commit_dly;
  rename_pkg::rn_result_t                        w_result;

  assign o_ready = ~(|w_empty) & ~i_flush;
  assign w_fire  = i_valid & o_ready;

  // --------------------------------------------------
  // per-lane free lists
  // --------------------------------------------------
  generate
    for (genvar d = 0; d < rename_pkg::DISP_SIZE; d++) begin : g_lane
      assign w_alloc[d]      = i_group.inst[d].valid & i_group.inst[d].rd_valid &
                               (i_group.inst[d].rd_regidx != '0);
      assign w_alloc_fire[d] = w_fire & w_alloc[d];
      assign w_new_rnid[d]   = w_alloc[d] ? w_pop_id[d] : '0;   // x0 and no-rd get 0

      // live commit frees the old id, dead commit its own new id
      assign w_push[d]    = r_commit_dly.commit & r_commit_dly.lane[d].rd_valid &
                            (r_commit_dly.lane[d].rd_regidx != '0);
      assign w_push_id[d] = r_commit_dly.lane[d].dead ? r_commit_dly.lane[d].rnid :
                                                        r_commit_dly.lane[d].old_rnid;

      rn_freelist #(
        .INIT_BASE (rename_pkg::ARCH_REGS + rename_pkg::FLIST_SIZE * d)
      ) u_freelist (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (w_push[d]),
        .i_push_id (w_push_id[d]),
        .i_pop     (w_alloc_fire[d]),
        .o_pop_id  (w_pop_id[d]),
        .o_empty   (w_empty[d])
      );
    end
  endgenerate

  rn_map_table u_map_table (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_group       (i_group),
    .o_src_rnid    (w_map_src_rnid),
    .o_rd_old_rnid (w_map_old_rnid),
    .i_update      (w_alloc_fire),
    .i_update_rnid (w_new_rnid),
    .i_restore     (i_flush),
    .i_restore_map (w_cmt_map)
  );

  rn_commit_map u_commit_map (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_commit  (i_commit),
    .o_map     (w_cmt_map)
  );

  rn_group_bypass u_bypass (
    .i_group        (i_group),
    .i_new_rnid     (w_new_rnid),
    .i_map_src_rnid (w_map_src_rnid),
    .i_map_old_rnid (w_map_old_rnid),
    .o_src_rnid     (w_src_rnid),
    .o_src_fwd      (w_src_fwd),
    .o_rd_old_rnid  (w_rd_old_rnid)
  );

  rn_busy_table u_busy_table (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_rnid       (w_src_rnid),
    .o_ready      (w_busy_ready),
    .i_alloc      (w_alloc_fire),
    .i_alloc_rnid (w_new_rnid),
    .i_wb         (i_wb)
  );

  // --------------------------------------------------
  // output packing
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < rename_pkg::DISP_SIZE; d++) begin
      w_result.inst[d].valid       = i_group.inst[d].valid;
      w_result.inst[d].rd_valid    = i_group.inst[d].rd_valid;
      w_result.inst[d].rd_regidx   = i_group.inst[d].rd_regidx;
      w_result.inst[d].rd_rnid     = w_new_rnid[d];
      w_result.inst[d].rd_old_rnid = w_rd_old_rnid[d];
      w_result.inst[d].src_rnid    = w_src_rnid[d];
      w_result.inst[d].src_ready   = w_busy_ready[d] & ~w_src_fwd[d];   // fwd never ready
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid      <= 1'b0;
      r_commit_dly <= '0;
    end else begin
      o_valid      <= w_fire;
      r_commit_dly <= i_commit;   // pushes land one edge after commit
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      o_group <= w_result;
    end
  end

endmodule

/* tb/tb_rename.sv */
`timescale 1ns/1ns

module tb_rename;

  localparam int          CLK_HALF  = 4;
  localparam int unsigned SEED      = 32'h02d86b6b;
  localparam string       DATA_FILE = "tb/rename_testdata.txt";

  logic                   clk = 1'b0;
  logic                   reset_n;
  logic                   valid;
  rename_pkg::rn_group_t  group;
  logic                   ready;
  logic                   out_valid;
  rename_pkg::rn_result_t out_group;
  rename_pkg::rn_wb_t     wb [rename_pkg::WB_PORTS];
  rename_pkg::rn_commit_t commit;
  logic                   flush;

  int f [23];          // numbers of the record being run
  int n_records = 0;

  rn_rename_top uut (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_valid   (valid),
    .i_group   (group),
    .o_ready   (ready),
    .o_valid   (out_valid),
    .o_group   (out_group),
    .i_wb      (wb),
    .i_commit  (commit),
    .i_flush   (flush)
  );

  always #CLK_HALF clk = ~clk;

  task automatic check_equal(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic drive_idle();
    valid  = 1'b0;
    group  = '0;
    commit = '0;
    flush  = 1'b0;
    for (int p = 0; p < rename_pkg::WB_PORTS; p++) begin
      wb[p] = '0;
    end
  endtask

  // --------------------------------------------------
  // data file parsing
  // --------------------------------------------------
  task automatic open_data(output int fd);
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", DATA_FILE);
      $display("ERRORS FOUND");
      $fatal(1, "no stimulus file");
    end
  endtask

  function automatic void skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != -1 && c != "\n") begin
      c = $fgetc(fd);
    end
  endfunction

  // next record letter or -1 at end of file
  // lines starting with # are skipped
  function automatic int next_tag(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        skip_line(fd);
      end else if (c > " ") begin
        return c;
      end
      c = $fgetc(fd);
    end
    return -1;
  endfunction

  task automatic read_fields(input int fd, input int n);
    int code;
    for (int i = 0; i < n; i++) begin
      code = $fscanf(fd, "%d", f[i]);
      if (code != 1) begin
        $display("the stimulus file has a short or malformed record");
        $display("ERRORS FOUND");
        $fatal(1, "bad stimulus record");
      end
    end
  endtask

  // --------------------------------------------------
  // record handlers start on a falling edge
  // --------------------------------------------------
  task automatic rename_and_check();
    int    b;
    int    e;
    string lane;
    for (int d = 0; d < rename_pkg::DISP_SIZE; d++) begin
      b = 5 * d;
      group.inst[d].valid     = f[b][0];
      group.inst[d].rd_valid  = f[b+1][0];
      group.inst[d].rd_regidx = f[b+2][rename_pkg::AREG_W-1:0];
      for (int s = 0; s < rename_pkg::NUM_SRC; s++) begin
        group.inst[d].src[s].valid  = f[b][0];
        group.inst[d].src[s].regidx = f[b+3+s][rename_pkg::AREG_W-1:0];
      end
    end
    valid = 1'b1;
    #2;
    check_equal("o_ready", int'(ready), f[10]);
    @(negedge clk);
    drive_idle();
    check_equal("o_valid", int'(out_valid), f[10]);   // only a fire gives a result
    if (f[10] != 0) begin
      for (int d = 0; d < rename_pkg::DISP_SIZE; d++) begin
        b    = 5 * d;
        e    = 11 + 6 * d;
        lane = $sformatf("o_group.inst[%0d]", d);
        check_equal({lane, ".valid"}, int'(out_group.inst[d].valid), f[b]);
        check_equal({lane, ".rd_valid"}, int'(out_group.inst[d].rd_valid), f[b+1]);
        check_equal({lane, ".rd_regidx"}, int'(out_group.inst[d].rd_regidx), f[b+2]);
        check_equal({lane, ".rd_rnid"}, int'(out_group.inst[d].rd_rnid), f[e]);
        check_equal({lane, ".rd_old_rnid"}, int'(out_group.inst[d].rd_old_rnid), f[e+1]);
        for (int s = 0; s < rename_pkg::NUM_SRC; s++) begin
          check_equal($sformatf("%s.src_rnid[%0d]", lane, s),
                      int'(out_group.inst[d].src_rnid[s]), f[e+2+s]);
          check_equal($sformatf("%s.src_ready[%0d]", lane, s),
                      int'(out_group.inst[d].src_ready[s]), f[e+4+s]);
        end
      end
    end
  endtask

  // writeback shares its cycle with the next record
  task automatic hold_writeback();
    for (int p = 0; p < rename_pkg::WB_PORTS; p++) begin
      wb[p].valid = f[2*p][0];
      wb[p].rnid  = f[2*p+1][rename_pkg::RNID_W-1:0];
    end
  endtask

  task automatic pulse_commit();
    commit.commit = 1'b1;
    for (int d = 0; d < rename_pkg::DISP_SIZE; d++) begin
      commit.lane[d].rd_valid  = f[5*d][0];
      commit.lane[d].dead      = f[5*d+1][0];
      commit.lane[d].rd_regidx = f[5*d+2][rename_pkg::AREG_W-1:0];
      commit.lane[d].rnid      = f[5*d+3][rename_pkg::RNID_W-1:0];
      commit.lane[d].old_rnid  = f[5*d+4][rename_pkg::RNID_W-1:0];
    end
    @(negedge clk);
    drive_idle();
  endtask

  initial begin : main
    int          fd;
    int          tag;
    int          gap;
    int unsigned discard;
    discard = $urandom(SEED);
    drive_idle();
    reset_n = 1'b0;
    open_data(fd);
    tag = next_tag(fd);
    while (tag != -1) begin     // first pass only sizes the watchdog
      n_records++;
      skip_line(fd);
      tag = next_tag(fd);
    end
    $fclose(fd);
    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    #2;
    check_equal("o_valid", int'(out_valid), 0);
    check_equal("o_ready", int'(ready), 1);
    @(negedge clk);
    open_data(fd);
    tag = next_tag(fd);
    while (tag != -1) begin
      case (tag)
        "R": begin
          read_fields(fd, 23);
          rename_and_check();
        end
        "W": begin
          read_fields(fd, 4);
          hold_writeback();
        end
        "C": begin
          read_fields(fd, 10);
          pulse_commit();
        end
        "F": begin
          flush = 1'b1;
          #2;
          check_equal("o_ready", int'(ready), 0);   // no group taken during a flush
          @(negedge clk);
          drive_idle();
        end
        "N": begin
          @(negedge clk);
          drive_idle();
        end
        default: begin
          $display("unknown record type %c in the stimulus file", tag);
          $display("ERRORS FOUND");
          $fatal(1, "unknown record");
        end
      endcase
      if (tag != "W") begin
        gap = int'($urandom % 3);   // idle cycles between records
        repeat (gap) @(negedge clk);
      end
      tag = next_tag(fd);
    end
    $fclose(fd);
    $display("NO ERRORS");
    $finish;
  end

  initial begin : watchdog
    wait (n_records > 0);
    repeat (n_records * 20 + 100) @(posedge clk);
    $display("timeout after %0d cycles, the run did not finish", n_records * 20 + 100);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog timeout");
  end

endmodule

/* tb/rename_testdata.txt */
# R v rv rd src0 src1 (lane 0, lane 1)  ready  rnid old src0 src1 rdy0 rdy1 (lane 0, lane 1)
# W v0 id0 v1 id1 / C rv dead rd new old (lane 0, lane 1) / F flush / N idle cycle
R 1 1 3 1 2  1 1 4 1 2  1  32 3 1 2 1 1  48 4 1 2 1 1
R 1 1 5 3 4  1 1 5 5 0  1  33 5 32 48 0 0  49 33 33 0 0 1
R 1 1 0 5 3  1 1 6 0 4  1  0 0 49 32 0 0  50 6 0 48 1 0
W 1 32 0 0
R 1 0 0 3 4  0 0 0 0 0  1  0 0 32 48 1 0  0 0 0 0 1 1
W 1 48 1 33
R 1 0 0 4 5  1 1 8 3 6  1  0 0 48 49 1 0  51 8 32 50 1 0
R 1 1 9 9 0  0 0 0 0 0  1  34 9 9 0 1 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  35 34 34 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  36 35 35 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  37 36 36 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  38 37 37 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  39 38 38 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  40 39 39 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  41 40 40 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  42 41 41 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  43 42 42 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  44 43 43 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  45 44 44 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  46 45 45 0 0 1  0 0 0 0 1 1
R 1 1 9 9 0  0 0 0 0 0  1  47 46 46 0 0 1  0 0 0 0 1 1
R 1 1 10 0 0  0 0 0 0 0  0  0 0 0 0 0 0  0 0 0 0 0 0
C 1 0 3 32 3  1 0 4 48 4
C 1 0 5 33 5  1 0 5 49 33
R 1 1 10 9 3  0 0 0 0 0  1  3 10 47 32 0 1  0 0 0 0 1 1
R 1 1 11 10 0  1 1 10 11 10  1  5 11 3 0 0 1  52 3 5 3 0 0
C 1 0 8 51 8  1 1 6 50 6
C 1 1 9 34 9  1 1 10 52 3
F
R 1 1 12 9 10  1 1 13 8 11  1  8 12 9 10 1 1  53 13 51 11 0 1
W 0 0 1 51
R 1 1 12 12 8  0 0 0 0 0  1  34 8 8 51 0 1  0 0 0 0 1 1
N

/* files.f */
logic/rename_pkg.sv
logic/rn_freelist.sv
logic/rn_map_table.sv
logic/rn_commit_map.sv
logic/rn_busy_table.sv
logic/rn_group_bypass.sv
logic/rn_rename_top.sv
tb/tb_rename.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the rename testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_rename -o tb_rename &&
./obj_dir/tb_rename ||
exit 1
